/* hw/mvt_pkg.sv */
package mvt_pkg;

    // ####################
    // data path
    // ####################

    // width of matrix elements, vector elements and result words
    localparam int data_w = 32;

    // ####################
    // load broadcast
    // ####################

    // which array a broadcast word belongs to, in stream order
    typedef enum logic [2:0]
    {
        kind_a,
        kind_y1,
        kind_y2,
        kind_x1,
        kind_x2
    } load_kind_e;

endpackage

/* hw/mvt_if.sv */
// job words from the loader to every lane and to the drain
interface load_bus
    import mvt_pkg::*;
#(
    parameter int vec_len = 8
)
();
    localparam int idx_w = (vec_len > 1) ? $clog2(vec_len) : 1;

    logic              valid;
    load_kind_e        kind;
    // vector words carry their element index in row
    logic [idx_w-1:0]  row;
    logic [idx_w-1:0]  col;
    logic [data_w-1:0] data;
    // one cycle after the last word of a job
    logic              start;

    modport source
    (
        output valid,
        output kind,
        output row,
        output col,
        output data,
        output start
    );

    modport sink
    (
        input valid,
        input kind,
        input row,
        input col,
        input data,
        input start
    );

endinterface

// x1 words, then x2 column partials, from one lane to the drain
interface lane_result
    import mvt_pkg::*;
();
    logic              valid;
    logic              ready;
    logic [data_w-1:0] data;
    logic              last;

    modport source
    (
        output valid,
        input  ready,
        output data,
        output last
    );

    modport sink
    (
        input  valid,
        output ready,
        input  data,
        input  last
    );

endinterface

/* hw/mvt_loader.sv */
module mvt_loader
    import mvt_pkg::*;
#(
    parameter int vec_len = 8
)
(
    input  logic              ap_clk,
    input  logic              rst_n,
    input  logic              in_valid,
    output logic              in_ready,
    input  logic [data_w-1:0] in_data,
    input  logic              lanes_idle,
    load_bus.source           load
);
    localparam int idx_w = (vec_len > 1) ? $clog2(vec_len) : 1;
    localparam logic [idx_w-1:0] idx_last = idx_w'(vec_len - 1);

    load_kind_e       kind_q;
    logic [idx_w-1:0] row_q;
    logic [idx_w-1:0] col_q;
    logic             blocked;
    logic             final_q;
    logic             accept;
    logic             job_end;

    assign in_ready = !blocked;
    assign accept   = in_valid && !blocked;
    // last x2 element closes the job
    assign job_end  = (kind_q == kind_x2) && (row_q == idx_last);

    // ####################
    // word tagging
    // ####################

    // A is row-major with col inner, vectors only count row
    always_ff @(posedge ap_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            kind_q <= kind_a;
            row_q  <= '0;
            col_q  <= '0;
        end
        else if (accept)
        begin
            if (kind_q == kind_a && col_q != idx_last)
                col_q <= col_q + 1'b1;
            else
            begin
                col_q <= '0;
                if (row_q != idx_last)
                    row_q <= row_q + 1'b1;
                else
                begin
                    row_q  <= '0;
                    kind_q <= job_end ? kind_a : load_kind_e'(kind_q + 3'd1);
                end
            end
        end
    end

    // ####################
    // broadcast, start, input blocking
    // ####################

    always_ff @(posedge ap_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            load.valid <= 1'b0;
            load.start <= 1'b0;
            final_q    <= 1'b0;
            blocked    <= 1'b0;
        end
        else
        begin
            load.valid <= accept;
            final_q    <= accept && job_end;
            load.start <= final_q;
            // lanes still look idle until they see start, so wait past it
            if (accept && job_end)
                blocked <= 1'b1;
            else if (blocked && lanes_idle && !final_q && !load.start)
                blocked <= 1'b0;
        end
    end

    always_ff @(posedge ap_clk)
    begin
        if (accept)
        begin
            load.kind <= kind_q;
            load.row  <= row_q;
            load.col  <= col_q;
            load.data <= in_data;
        end
    end

endmodule

/* hw/mvt_lane.sv */
module mvt_lane
    import mvt_pkg::*;
#(
    parameter int vec_len = 8,
    parameter int lanes   = 4,
    parameter int lane_id = 0
)
(
    input  logic       ap_clk,
    input  logic       rst_n,
    load_bus.sink      load,
    lane_result.source result,
    output logic       idle
);
    localparam int rows_per_lane = vec_len / lanes;
    localparam int row_base      = lane_id * rows_per_lane;
    localparam int idx_w         = (vec_len > 1) ? $clog2(vec_len) : 1;
    localparam int r_w           = (rows_per_lane > 1) ? $clog2(rows_per_lane) : 1;
    // x1 words followed by one partial per column
    localparam int n_out         = rows_per_lane + vec_len;
    localparam int s_w           = $clog2(n_out);
    localparam logic [r_w-1:0]   rows_last = r_w'(rows_per_lane - 1);
    localparam logic [idx_w-1:0] idx_last  = idx_w'(vec_len - 1);

    typedef enum logic [1:0]
    {
        st_load,
        st_compute,
        st_send
    } lane_state_e;

    lane_state_e       state;
    logic [data_w-1:0] a_mem    [rows_per_lane][vec_len];
    logic [data_w-1:0] y1_mem   [vec_len];
    logic [data_w-1:0] y2_mem   [rows_per_lane];
    logic [data_w-1:0] x1_acc   [rows_per_lane];
    logic [data_w-1:0] part_mem [vec_len];
    logic [data_w-1:0] col_sum;
    logic [data_w-1:0] a_ij;
    logic [data_w-1:0] a_y2;
    logic [r_w-1:0]    ci;
    logic [idx_w-1:0]  cj;
    logic [s_w-1:0]    send_idx;
    logic              owned;
    logic [r_w-1:0]    lrow;

    // rows of A, slices of y2 and x1 belonging to this lane
    assign owned = (int'(load.row) >= row_base) && (int'(load.row) < row_base + rows_per_lane);
    assign lrow  = r_w'(int'(load.row) - row_base);

    assign a_ij = a_mem[ci][cj];
    assign a_y2 = a_ij * y2_mem[ci];

    // ####################
    // storage and MAC
    // ####################

    always_ff @(posedge ap_clk)
    begin
        if (load.valid)
        begin
            case (load.kind)
                kind_a:  if (owned) a_mem[lrow][load.col] <= load.data;
                kind_y1: y1_mem[load.row] <= load.data;
                kind_y2: if (owned) y2_mem[lrow] <= load.data;
                // accumulators start from the initial x1
                kind_x1: if (owned) x1_acc[lrow] <= load.data;
                default: ;
            endcase
        end
        if (load.start)
            col_sum <= '0;
        if (state == st_compute)
        begin
            x1_acc[ci] <= x1_acc[ci] + a_ij * y1_mem[cj];
            // column partial done on the last row of the lane
            if (ci == rows_last)
            begin
                part_mem[cj] <= col_sum + a_y2;
                col_sum      <= '0;
            end
            else
                col_sum <= col_sum + a_y2;
        end
    end

    // ####################
    // control
    // ####################

    always_ff @(posedge ap_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state    <= st_load;
            ci       <= '0;
            cj       <= '0;
            send_idx <= '0;
        end
        else
        begin
            case (state)
                st_load:
                    if (load.start)
                        state <= st_compute;
                st_compute:
                begin
                    // column outer, row inner
                    if (ci == rows_last)
                    begin
                        ci <= '0;
                        if (cj == idx_last)
                        begin
                            cj    <= '0;
                            state <= st_send;
                        end
                        else
                            cj <= cj + 1'b1;
                    end
                    else
                        ci <= ci + 1'b1;
                end
                st_send:
                    if (result.ready)
                    begin
                        if (result.last)
                        begin
                            send_idx <= '0;
                            state    <= st_load;
                        end
                        else
                            send_idx <= send_idx + 1'b1;
                    end
                default:
                    state <= st_load;
            endcase
        end
    end

    assign idle         = (state == st_load);
    assign result.valid = (state == st_send);
    assign result.last  = (send_idx == s_w'(n_out - 1));

    always_comb
    begin
        if (send_idx < s_w'(rows_per_lane))
            result.data = x1_acc[r_w'(send_idx)];
        else
            result.data = part_mem[idx_w'(send_idx - s_w'(rows_per_lane))];
    end

endmodule

/* hw/mvt_drain.sv */
module mvt_drain
    import mvt_pkg::*;
#(
    parameter int vec_len = 8,
    parameter int lanes   = 4
)
(
    input  logic              ap_clk,
    input  logic              rst_n,
    load_bus.sink             load,
    lane_result.sink          results [lanes],
    output logic              out_valid,
    input  logic              out_ready,
    output logic [data_w-1:0] out_data,
    output logic              out_last,
    output logic [3:0]        job_sig
);
    localparam int rows_per_lane = vec_len / lanes;
    localparam int idx_w         = (vec_len > 1) ? $clog2(vec_len) : 1;
    localparam int r_w           = (rows_per_lane > 1) ? $clog2(rows_per_lane) : 1;
    localparam int l_w           = (lanes > 1) ? $clog2(lanes) : 1;
    localparam logic [r_w-1:0] rows_last = r_w'(rows_per_lane - 1);
    localparam logic [l_w-1:0] lane_max  = l_w'(lanes - 1);

    typedef enum logic [1:0]
    {
        collect_x1,
        sum_x2,
        idle
    } drain_state_e;

    drain_state_e      state;
    logic [data_w-1:0] x2_mem    [vec_len];
    logic [data_w-1:0] lane_data [lanes];
    logic [lanes-1:0]  lane_valid;
    logic [lanes-1:0]  lane_last;
    logic [lanes-1:0]  lane_ready;
    logic [l_w-1:0]    cur_lane;
    logic [r_w-1:0]    x1_cnt;
    logic [idx_w-1:0]  col_q;
    logic [data_w-1:0] sig_acc;
    logic [data_w-1:0] x2_sum;
    logic [data_w-1:0] next_word;
    logic [data_w-1:0] sig_full;
    logic [7:0]        sig_8;
    logic              out_free;
    logic              take;
    logic              word_last;

    for (genvar k = 0; k < lanes; k++)
    begin : g_lane_port
        assign lane_valid[k]    = results[k].valid;
        assign lane_data[k]     = results[k].data;
        assign lane_last[k]     = results[k].last;
        assign results[k].ready = lane_ready[k];
    end

    // output register can take a word this cycle
    assign out_free = !out_valid || out_ready;

    // ####################
    // word select and x2 sum
    // ####################

    always_comb
    begin
        x2_sum = x2_mem[col_q];
        for (int k = 0; k < lanes; k++)
            x2_sum = x2_sum + lane_data[k];

        lane_ready = '0;
        take       = 1'b0;
        next_word  = x2_sum;
        word_last  = 1'b0;
        case (state)
            collect_x1:
            begin
                take                 = out_free && lane_valid[cur_lane];
                lane_ready[cur_lane] = out_free;
                next_word            = lane_data[cur_lane];
            end
            sum_x2:
            begin
                // one partial from every lane per column
                take       = out_free && (&lane_valid);
                lane_ready = {lanes{take}};
                word_last  = &lane_last;
            end
            default: ;
        endcase
    end

    // signature folded 32 -> 8 -> 4
    assign sig_full = sig_acc ^ next_word;
    assign sig_8    = sig_full[7:0] ^ sig_full[15:8] ^ sig_full[23:16] ^ sig_full[31:24];

    // ####################
    // control
    // ####################

    always_ff @(posedge ap_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state     <= collect_x1;
            cur_lane  <= '0;
            x1_cnt    <= '0;
            col_q     <= '0;
            out_valid <= 1'b0;
            out_last  <= 1'b0;
            sig_acc   <= '0;
            job_sig   <= '0;
        end
        else
        begin
            if (out_free)
            begin
                out_valid <= take;
                out_last  <= take && word_last;
            end
            if (take)
            begin
                if (word_last)
                begin
                    sig_acc <= '0;
                    job_sig <= sig_8[7:4] ^ sig_8[3:0];
                end
                else
                    sig_acc <= sig_full;
            end
            case (state)
                collect_x1:
                    if (take)
                    begin
                        // x1 words come lane by lane
                        if (x1_cnt == rows_last)
                        begin
                            x1_cnt <= '0;
                            if (cur_lane == lane_max)
                            begin
                                cur_lane <= '0;
                                state    <= sum_x2;
                            end
                            else
                                cur_lane <= cur_lane + 1'b1;
                        end
                        else
                            x1_cnt <= x1_cnt + 1'b1;
                    end
                sum_x2:
                    if (take)
                    begin
                        if (word_last)
                        begin
                            col_q <= '0;
                            state <= idle;
                        end
                        else
                            col_q <= col_q + 1'b1;
                    end
                // final word is in the output register
                idle:
                    if (out_ready)
                        state <= collect_x1;
                default:
                    state <= collect_x1;
            endcase
        end
    end

    always_ff @(posedge ap_clk)
    begin
        if (load.valid && load.kind == kind_x2)
            x2_mem[load.row] <= load.data;
        if (take)
            out_data <= next_word;
    end

endmodule

/* hw/mvt_top.sv */
module mvt_top
    import mvt_pkg::*;
#(
    parameter int vec_len = 8,
    parameter int lanes   = 4
)
(
    input  logic              ap_clk,
    input  logic              rst_n,
    input  logic              in_valid,
    output logic              in_ready,
    input  logic [data_w-1:0] in_data,
    output logic              out_valid,
    input  logic              out_ready,
    output logic [data_w-1:0] out_data,
    output logic              out_last,
    output logic [3:0]        job_sig
);
    logic [lanes-1:0] lane_idle;
    logic             lanes_idle;

    load_bus #(.vec_len(vec_len)) load_if ();
    lane_result                   res_if [lanes] ();

    // input opens again once every lane has drained
    assign lanes_idle = &lane_idle;

    mvt_loader #(
        .vec_len    (vec_len)
    ) u_loader (
        .ap_clk     (ap_clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_data    (in_data),
        .lanes_idle (lanes_idle),
        .load       (load_if)
    );

    // ####################
    // compute lanes
    // ####################

    for (genvar g = 0; g < lanes; g++)
    begin : g_lane
        mvt_lane #(
            .vec_len (vec_len),
            .lanes   (lanes),
            .lane_id (g)
        ) u_lane (
            .ap_clk  (ap_clk),
            .rst_n   (rst_n),
            .load    (load_if),
            .result  (res_if[g]),
            .idle    (lane_idle[g])
        );
    end

    mvt_drain #(
        .vec_len   (vec_len),
        .lanes     (lanes)
    ) u_drain (
        .ap_clk    (ap_clk),
        .rst_n     (rst_n),
        .load      (load_if),
        .results   (res_if),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data),
        .out_last  (out_last),
        .job_sig   (job_sig)
    );

endmodule

/* verif/tb_mvt.sv */
module tb_mvt
    import mvt_pkg::*;
();
    localparam int vec_len        = 8;
    localparam int lanes          = 4;
    localparam int n_jobs         = 6;
    localparam int job_words      = vec_len * vec_len + 4 * vec_len;
    localparam int out_words      = 2 * vec_len;
    localparam int compute_cycles = (vec_len / lanes) * vec_len;
    localparam int cycle_limit    = n_jobs * (job_words + out_words + compute_cycles) * 4 + 500;
    localparam int reopen_limit   = 64;
    localparam logic [31:0] seed  = 32'he4b67686;

    logic              ap_clk;
    logic              rst_n;
    logic              in_valid;
    logic              in_ready;
    logic [data_w-1:0] in_data;
    logic              out_valid;
    logic              out_ready;
    logic [data_w-1:0] out_data;
    logic              out_last;
    logic [3:0]        job_sig;

    // job stream and expected results of all jobs back to back
    logic [31:0] in_words  [$];
    logic [31:0] exp_words [$];
    logic [3:0]  exp_sig   [n_jobs];
    logic [31:0] gap_in;
    logic [31:0] gap_out;

    int          errors      = 0;
    int          cycle       = 0;
    int          out_job     = 0;
    int          out_cnt     = 0;
    int          words_seen  = 0;
    logic        prev_stall  = 1'b0;
    logic [31:0] prev_data   = '0;
    logic        prev_last   = 1'b0;
    logic        reopen_wait = 1'b0;
    int          reopen_cnt  = 0;

    mvt_top dut0
    (
        .ap_clk    (ap_clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data),
        .out_last  (out_last),
        .job_sig   (job_sig)
    );

    initial
    begin
        ap_clk = 1'b0;
        forever #5 ap_clk = ~ap_clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // fold a job's xor word to 8 then 4 bits
    function automatic logic [3:0] fold_sig(input logic [31:0] w);
        logic [7:0] b;
        b = w[7:0] ^ w[15:8] ^ w[23:16] ^ w[31:24];
        return b[7:4] ^ b[3:0];
    endfunction

    // ####################
    // reference model
    // ####################

    task automatic build_jobs();
        logic [31:0] rng;
        logic [31:0] a   [vec_len][vec_len];
        // y1, y2, x1, x2 in stream order
        logic [31:0] vec [4][vec_len];
        logic [31:0] acc;
        logic [31:0] sig;
        rng = seed;
        for (int job = 0; job < n_jobs; job++)
        begin
            for (int i = 0; i < vec_len; i++)
            begin
                for (int j = 0; j < vec_len; j++)
                begin
                    rng = xorshift(rng);
                    a[i][j] = rng;
                    in_words.push_back(rng);
                end
            end
            for (int v = 0; v < 4; v++)
            begin
                for (int i = 0; i < vec_len; i++)
                begin
                    rng = xorshift(rng);
                    vec[v][i] = rng;
                    in_words.push_back(rng);
                end
            end
            sig = '0;
            // x1 + A * y1
            for (int i = 0; i < vec_len; i++)
            begin
                acc = vec[2][i];
                for (int j = 0; j < vec_len; j++)
                    acc = acc + a[i][j] * vec[0][j];
                exp_words.push_back(acc);
                sig = sig ^ acc;
            end
            // x2 + transpose(A) * y2
            for (int j = 0; j < vec_len; j++)
            begin
                acc = vec[3][j];
                for (int i = 0; i < vec_len; i++)
                    acc = acc + a[i][j] * vec[1][i];
                exp_words.push_back(acc);
                sig = sig ^ acc;
            end
            exp_sig[job] = fold_sig(sig);
        end
        gap_in  = xorshift(rng);
        gap_out = xorshift(gap_in ^ seed);
    endtask

    // ####################
    // stimulus
    // ####################

    initial
    begin
        int idx;
        int done_jobs;
        build_jobs();
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_data   = '0;
        out_ready = 1'b0;
        idx       = 0;
        done_jobs = 0;
        repeat (8) @(posedge ap_clk);
        rst_n <= 1'b1;
        while (done_jobs < n_jobs)
        begin
            @(posedge ap_clk);
            if (in_valid && in_ready)
                idx++;
            if (out_valid && out_ready && out_last)
                done_jobs++;
            gap_in  = xorshift(gap_in);
            gap_out = xorshift(gap_out);
            // first two jobs run without gaps
            if (idx < in_words.size())
            begin
                in_valid <= (idx < 2 * job_words) || (gap_in[1:0] != 2'b00);
                in_data  <= in_words[idx];
            end
            else
                in_valid <= 1'b0;
            out_ready <= (done_jobs < 2) || (gap_out[2:1] != 2'b00);
        end
        in_valid <= 1'b0;
        while (!in_ready)
            @(posedge ap_clk);
        repeat (2) @(posedge ap_clk);
        @(negedge ap_clk);
        $display("%0d errors, %0d of %0d jobs, %0d words checked",
                 errors, out_job, n_jobs, words_seen);
        if (errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

    // ####################
    // checks
    // ####################

    always @(posedge ap_clk)
    begin
        logic [31:0] want;
        cycle++;
        if (cycle >= cycle_limit)
        begin
            $display("timeout after %0d cycles with %0d of %0d jobs finished",
                     cycle, out_job, n_jobs);
            $display("%0d errors, %0d of %0d jobs, %0d words checked",
                     errors, out_job, n_jobs, words_seen);
            $display("Regression failed");
            $finish;
        end
        else if (!rst_n)
        begin
            if (cycle > 1)
                assert (!out_valid && !out_last)
                else
                begin
                    errors++;
                    $display("out_valid or out_last high during reset at %0t", $time);
                end
        end
        else
        begin
            // held output while the sink stalls
            if (prev_stall)
            begin
                assert (out_valid)
                else
                begin
                    errors++;
                    $display("out_valid dropped under back-pressure at %0t", $time);
                end
                assert (out_data == prev_data)
                else
                begin
                    errors++;
                    $display("** Error at %0t: out_data = %h, expected %h",
                             $time, out_data, prev_data);
                end
                assert (out_last == prev_last)
                else
                begin
                    errors++;
                    $display("** Error at %0t: out_last = %b, expected %b",
                             $time, out_last, prev_last);
                end
            end
            if (reopen_wait)
            begin
                if (in_ready)
                    reopen_wait = 1'b0;
                else
                begin
                    reopen_cnt++;
                    assert (reopen_cnt <= reopen_limit)
                    else
                    begin
                        errors++;
                        $display("in_ready still low %0d cycles after out_last", reopen_cnt);
                        reopen_wait = 1'b0;
                    end
                end
            end
            if (out_valid && out_ready)
            begin
                assert (exp_words.size() > 0)
                else
                begin
                    errors++;
                    $display("output word after the last expected job at %0t", $time);
                end
                if (exp_words.size() > 0)
                begin
                    want = exp_words.pop_front();
                    assert (out_data == want)
                    else
                    begin
                        errors++;
                        $display("** Error at %0t: out_data = %h, expected %h",
                                 $time, out_data, want);
                    end
                end
                assert (out_last == (out_cnt == out_words - 1))
                else
                begin
                    errors++;
                    $display("** Error at %0t: out_last = %b, expected %b",
                             $time, out_last, out_cnt == out_words - 1);
                end
                out_cnt++;
                words_seen++;
                if (out_last)
                begin
                    if (out_job < n_jobs)
                        assert (job_sig == exp_sig[out_job])
                        else
                        begin
                            errors++;
                            $display("** Error at %0t: job_sig = %h, expected %h",
                                     $time, job_sig, exp_sig[out_job]);
                        end
                    out_job++;
                    out_cnt     = 0;
                    reopen_wait = 1'b1;
                    reopen_cnt  = 0;
                end
            end
            prev_stall = out_valid && !out_ready;
            prev_data  = out_data;
            prev_last  = out_last;
        end
    end

endmodule

/* project.f */
hw/mvt_pkg.sv
hw/mvt_if.sv
hw/mvt_loader.sv
hw/mvt_lane.sv
hw/mvt_drain.sv
hw/mvt_top.sv
verif/tb_mvt.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the mvt testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module tb_mvt -Mdir obj_dir -o tb_mvt
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/tb_mvt)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "Regression passed" <<< "$sim_out"; then
    exit 0
fi
echo "pass message not found"
exit 1
